//--- hdl/fetch_pkg.sv
// ---------------------------------------------------------------------
// Fetch package
// Address and word widths, boot ROM layout and the fetch address views
// ---------------------------------------------------------------------
`default_nettype none

package fetch_pkg;

    localparam int unsigned ADDR_SIZE        = 40;   // Virtual address
    localparam int unsigned INSTR_SIZE       = 32;
    localparam int unsigned VPN_SIZE         = 28;
    localparam int unsigned IDX_SIZE         = 12;   // Page offset
    localparam int unsigned BROM_OFFSET_SIZE = 19;
    localparam int unsigned BROM_SIZE        = 4096; // Bytes
    localparam int unsigned BROM_ADDR_SIZE   = 24;

    // ROM word = byte address ^ pattern
    localparam logic [INSTR_SIZE-1:0] BROM_PATTERN = 32'hB007_0013;

    localparam logic [ADDR_SIZE-1:0] RESET_PC = '0;

    // One fetch address, two decodings
    typedef union packed {
        struct packed {
            logic [VPN_SIZE-1:0] vpn;
            logic [IDX_SIZE-1:0] idx;
        } cache;
        struct packed {
            logic [ADDR_SIZE-BROM_OFFSET_SIZE-1:0] unused;
            logic [BROM_OFFSET_SIZE-1:0]           offset;
        } rom;
    } fetch_vaddr_u;

endpackage

`default_nettype wire

//--- hdl/icache_pkg.sv
// ---------------------------------------------------------------------
// Instruction cache package
// Geometry, refill latency and translation limit of the cache
// ---------------------------------------------------------------------
`default_nettype none

package icache_pkg;

    localparam int unsigned LINE_BITS     = 128;  // Four words
    localparam int unsigned NUM_LINES     = 64;
    localparam int unsigned REFILL_CYCLES = 6;
    localparam int unsigned OFFSET_BITS   = $clog2(LINE_BITS / 8);
    localparam int unsigned INDEX_BITS    = $clog2(NUM_LINES);
    localparam int unsigned CNT_BITS      = $clog2(REFILL_CYCLES);

    localparam logic [CNT_BITS-1:0] REFILL_LOAD = CNT_BITS'(REFILL_CYCLES - 1);

    // Highest legal VPN with translation on
    localparam logic [27:0] VPN_LIMIT = 28'h0000F;

    // Memory image word = byte address ^ pattern
    localparam logic [31:0] INSTR_PATTERN = 32'h5EED_C0DE;

endpackage

`default_nettype wire

//--- hdl/pc_gen.sv
// ---------------------------------------------------------------------
// Program counter sequencer
// One fetch in flight, with redirect, stall and held invalidate
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pc_gen (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  logic                                stall_i,
    input  logic                                redirect_valid_i,
    input  logic [fetch_pkg::ADDR_SIZE-1:0]     redirect_pc_i,
    input  logic                                invalidate_i,
    input  logic                                req_ready_i,
    input  logic                                resp_valid_i,
    input  logic [fetch_pkg::INSTR_SIZE-1:0]    resp_data_i,
    input  logic                                resp_fault_i,
    output logic                                req_valid_o,
    output fetch_pkg::fetch_vaddr_u             req_vaddr_o,
    output logic                                req_kill_o,
    output logic                                req_inval_buffer_o,
    output logic                                req_inval_cache_o,
    output logic                                instr_valid_o,
    output logic [fetch_pkg::ADDR_SIZE-1:0]     instr_pc_o,
    output logic [fetch_pkg::INSTR_SIZE-1:0]    instr_o,
    output logic                                instr_fault_o
);

    logic                            waiting_q;     // Fetch outstanding
    logic                            inval_pend_q;  // Invalidate held for idle
    logic [fetch_pkg::ADDR_SIZE-1:0] pc_q;

    // No new fetch while an invalidate waits or a redirect lands
    assign req_valid_o        = ~waiting_q & ~stall_i & ~inval_pend_q & ~redirect_valid_i;
    assign req_vaddr_o        = pc_q;
    assign req_kill_o         = redirect_valid_i;   // Abandons a refill
    assign req_inval_buffer_o = redirect_valid_i;
    assign req_inval_cache_o  = inval_pend_q & ~waiting_q;

    // A response that meets a redirect is dropped
    assign instr_valid_o = waiting_q & resp_valid_i & ~redirect_valid_i;
    assign instr_pc_o    = pc_q;
    assign instr_o       = resp_data_i;
    assign instr_fault_o = resp_fault_i;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            waiting_q    <= 1'b0;
            inval_pend_q <= 1'b0;
            pc_q         <= fetch_pkg::RESET_PC;
        end else begin
            if (redirect_valid_i) begin
                pc_q      <= redirect_pc_i;
                waiting_q <= 1'b0;
            end else if (waiting_q) begin
                if (resp_valid_i) begin
                    pc_q      <= pc_q + fetch_pkg::ADDR_SIZE'(4);  // Faulted fetch advances too
                    waiting_q <= 1'b0;
                end
            end else if (req_valid_o && req_ready_i) begin
                waiting_q <= 1'b1;
            end
            if (invalidate_i) begin
                inval_pend_q <= 1'b1;
            end else if (req_inval_cache_o) begin
                inval_pend_q <= 1'b0;   // Pulse sent
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/icache_interface.sv
// ---------------------------------------------------------------------
// Instruction cache interface
// Routes each fetch to the boot ROM or the cache and picks the word
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module icache_interface (
    input  logic                                    clk_i,
    input  logic                                    rstn_i,
    input  logic                                    req_valid_i,
    input  fetch_pkg::fetch_vaddr_u                 req_vaddr_i,
    input  logic                                    req_kill_i,
    input  logic                                    req_inval_buffer_i,
    input  logic                                    req_inval_cache_i,
    input  logic [icache_pkg::LINE_BITS-1:0]        icache_resp_line_i,
    input  logic                                    icache_resp_valid_i,
    input  logic                                    icache_req_ready_i,
    input  logic                                    tlb_xcpt_i,
    input  logic                                    en_translation_i,
    input  logic                                    csr_spi_config_i,
    input  logic                                    brom_ready_i,
    input  logic                                    brom_resp_valid_i,
    input  logic [fetch_pkg::INSTR_SIZE-1:0]        brom_resp_data_i,
    output logic                                    icache_invalidate_o,
    output logic [fetch_pkg::IDX_SIZE-1:0]          icache_req_idx_o,
    output logic [fetch_pkg::VPN_SIZE-1:0]          icache_req_vpn_o,
    output logic                                    icache_req_kill_o,
    output logic                                    icache_req_valid_o,
    output logic [fetch_pkg::BROM_ADDR_SIZE-1:0]    brom_req_address_o,
    output logic                                    brom_req_valid_o,
    output logic                                    resp_valid_o,
    output logic [fetch_pkg::INSTR_SIZE-1:0]        resp_data_o,
    output logic                                    resp_fault_o,
    output logic                                    req_ready_o
);

    logic                            is_brom_access;
    logic                            is_brom_old_q;  // Source of the pending response
    logic                            do_request;
    logic                            outstanding_q;  // Only watched by the check below
    logic [fetch_pkg::ADDR_SIZE-1:0] old_pc_q;

    // Boot window only with translation off and SPI boot clear
    assign is_brom_access = ~en_translation_i & ~csr_spi_config_i &
        (fetch_pkg::ADDR_SIZE'(req_vaddr_i) < fetch_pkg::ADDR_SIZE'(fetch_pkg::BROM_SIZE));

    assign icache_req_valid_o = req_valid_i & ~req_inval_buffer_i & ~is_brom_access &
                                icache_req_ready_i;
    assign brom_req_valid_o   = req_valid_i & ~req_inval_buffer_i & is_brom_access &
                                brom_ready_i;
    assign do_request         = icache_req_valid_o | brom_req_valid_o;

    assign icache_req_vpn_o    = req_vaddr_i.cache.vpn;
    assign icache_req_idx_o    = req_vaddr_i.cache.idx;
    assign brom_req_address_o  = fetch_pkg::BROM_ADDR_SIZE'(req_vaddr_i.rom.offset);
    assign icache_req_kill_o   = req_kill_i;
    assign icache_invalidate_o = req_inval_cache_i;
    assign req_ready_o         = is_brom_access ? brom_ready_i : icache_req_ready_i;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            old_pc_q      <= '0;
            is_brom_old_q <= 1'b0;
        end else if (do_request) begin
            old_pc_q      <= req_vaddr_i;
            is_brom_old_q <= is_brom_access;
        end
    end

    // Word out of the line by PC bits 3:2, zero on a fault
    always_comb begin
        if (is_brom_old_q) begin
            resp_data_o = brom_resp_data_i;
        end else if (tlb_xcpt_i) begin
            resp_data_o = '0;
        end else begin
            resp_data_o = icache_resp_line_i[old_pc_q[3:2] * fetch_pkg::INSTR_SIZE +:
                                             fetch_pkg::INSTR_SIZE];
        end
    end

    assign resp_valid_o = is_brom_old_q ? brom_resp_valid_i
                                        : (icache_resp_valid_i | tlb_xcpt_i);
    assign resp_fault_o = ~is_brom_old_q & tlb_xcpt_i;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            outstanding_q <= 1'b0;
        end else if (do_request) begin
            outstanding_q <= 1'b1;
        end else if (resp_valid_o || req_kill_i) begin
            outstanding_q <= 1'b0;  // Answered or abandoned
        end
    end

    a_one_target: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(brom_req_valid_o && icache_req_valid_o));

    a_resp_after_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
        resp_valid_o |-> outstanding_q);

endmodule

`default_nettype wire

//--- hdl/icache_array.sv
// ---------------------------------------------------------------------
// Direct-mapped instruction cache
// Hit in one cycle, fixed-latency refill, page fault check, miss pulse
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module icache_array (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  logic                                req_valid_i,
    input  logic [fetch_pkg::VPN_SIZE-1:0]      req_vpn_i,
    input  logic [fetch_pkg::IDX_SIZE-1:0]      req_idx_i,
    input  logic                                req_kill_i,
    input  logic                                invalidate_i,
    input  logic                                en_translation_i,
    output logic                                req_ready_o,
    output logic                                resp_valid_o,
    output logic [icache_pkg::LINE_BITS-1:0]    resp_line_o,
    output logic                                tlb_xcpt_o,
    output logic                                miss_o
);

    logic [icache_pkg::LINE_BITS-1:0]                       data_q [icache_pkg::NUM_LINES];
    logic [fetch_pkg::ADDR_SIZE-icache_pkg::OFFSET_BITS-1:0] tag_q [icache_pkg::NUM_LINES];
    logic [icache_pkg::NUM_LINES-1:0]                       valid_q;

    fetch_pkg::fetch_vaddr_u             req_addr;
    fetch_pkg::fetch_vaddr_u             addr_q;     // Line being refilled
    logic [icache_pkg::INDEX_BITS-1:0]   req_set;
    logic [icache_pkg::INDEX_BITS-1:0]   fill_set;
    logic [icache_pkg::LINE_BITS-1:0]    fill_line;
    logic [icache_pkg::CNT_BITS-1:0]     cnt_q;
    logic                                refill_q;
    logic                                fault;
    logic                                hit;
    logic                                fill_done;

    always_comb begin
        req_addr.cache.vpn = req_vpn_i;
        req_addr.cache.idx = req_idx_i;
    end

    assign req_set  = req_addr[icache_pkg::OFFSET_BITS +: icache_pkg::INDEX_BITS];
    assign fill_set = addr_q[icache_pkg::OFFSET_BITS +: icache_pkg::INDEX_BITS];

    // Out-of-range page skips the lookup
    assign fault = en_translation_i & (req_vpn_i > icache_pkg::VPN_LIMIT);
    assign hit   = valid_q[req_set] &
                   (tag_q[req_set] == req_addr[fetch_pkg::ADDR_SIZE-1:icache_pkg::OFFSET_BITS]);

    assign req_ready_o = ~refill_q;
    assign fill_done   = refill_q & ~req_kill_i & (cnt_q == '0);

    // Memory image line built from the word addresses
    always_comb begin
        logic [fetch_pkg::ADDR_SIZE-1:0] word_addr;
        for (int w = 0; w < icache_pkg::LINE_BITS / fetch_pkg::INSTR_SIZE; w++) begin
            word_addr = addr_q;
            word_addr[icache_pkg::OFFSET_BITS-1:0] = {w[1:0], 2'b00};
            fill_line[w * fetch_pkg::INSTR_SIZE +: fetch_pkg::INSTR_SIZE] =
                word_addr[fetch_pkg::INSTR_SIZE-1:0] ^ icache_pkg::INSTR_PATTERN;
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            refill_q     <= 1'b0;
            cnt_q        <= '0;
            resp_valid_o <= 1'b0;
            tlb_xcpt_o   <= 1'b0;
            miss_o       <= 1'b0;
            valid_q      <= '0;
        end else begin
            resp_valid_o <= 1'b0;
            tlb_xcpt_o   <= 1'b0;
            miss_o       <= 1'b0;
            if (invalidate_i) begin
                valid_q <= '0;
            end
            if (!refill_q) begin
                if (req_valid_i) begin
                    if (fault) begin
                        tlb_xcpt_o <= 1'b1;
                    end else if (hit) begin
                        resp_valid_o <= 1'b1;
                    end else begin
                        refill_q <= 1'b1;
                        cnt_q    <= icache_pkg::REFILL_LOAD;
                        miss_o   <= 1'b1;  // PMU
                    end
                end
            end else if (req_kill_i) begin
                refill_q <= 1'b0;  // No response
            end else if (fill_done) begin
                refill_q          <= 1'b0;
                resp_valid_o      <= 1'b1;
                valid_q[fill_set] <= 1'b1;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // Storage and payload
    always_ff @(posedge clk_i) begin
        if (req_valid_i && !refill_q) begin
            addr_q      <= req_addr;
            resp_line_o <= data_q[req_set];
        end
        if (fill_done) begin
            data_q[fill_set] <= fill_line;
            tag_q[fill_set]  <= addr_q[fetch_pkg::ADDR_SIZE-1:icache_pkg::OFFSET_BITS];
            resp_line_o      <= fill_line;
        end
    end

    a_no_spurious_resp: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (resp_valid_o || tlb_xcpt_o) |-> !$past(req_ready_o && !req_valid_i));

endmodule

`default_nettype wire

//--- hdl/boot_rom.sv
// ---------------------------------------------------------------------
// Boot ROM
// Word read one cycle after the request, then busy for one cycle
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
    input  logic                                    clk_i,
    input  logic                                    rstn_i,
    input  logic                                    req_valid_i,
    input  logic [fetch_pkg::BROM_ADDR_SIZE-1:0]    req_address_i,
    output logic                                    ready_o,
    output logic                                    resp_valid_o,
    output logic [fetch_pkg::INSTR_SIZE-1:0]        resp_data_o
);

    logic                             busy_q;
    logic [fetch_pkg::INSTR_SIZE-1:0] word_addr;   // Word-aligned byte address

    assign ready_o = ~busy_q;

    always_comb begin
        word_addr = '0;
        word_addr[$clog2(fetch_pkg::BROM_SIZE)-1:2] =
            req_address_i[$clog2(fetch_pkg::BROM_SIZE)-1:2];
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q       <= 1'b0;
            resp_valid_o <= 1'b0;
        end else begin
            busy_q       <= req_valid_i & ready_o;  // Gap during the response
            resp_valid_o <= req_valid_i & ready_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && ready_o) begin
            resp_data_o <= word_addr ^ fetch_pkg::BROM_PATTERN;
        end
    end

    a_no_req_busy: assert property (@(posedge clk_i) disable iff (!rstn_i)
        req_valid_i |-> ready_o);

endmodule

`default_nettype wire

//--- hdl/fetch_frontend.sv
// ---------------------------------------------------------------------
// Instruction fetch front end
// PC sequencer, cache interface, instruction cache and boot ROM
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  logic                                redirect_valid_i,
    input  logic [fetch_pkg::ADDR_SIZE-1:0]     redirect_pc_i,
    input  logic                                invalidate_i,
    input  logic                                stall_i,
    input  logic                                en_translation_i,
    input  logic                                csr_spi_config_i,
    output logic                                instr_valid_o,
    output logic [fetch_pkg::ADDR_SIZE-1:0]     instr_pc_o,
    output logic [fetch_pkg::INSTR_SIZE-1:0]    instr_o,
    output logic                                instr_fault_o,
    output logic                                icache_miss_o
);

    // Sequencer and interface
    logic                                   fetch_req_valid, req_fetch_ready;
    fetch_pkg::fetch_vaddr_u                fetch_vaddr;
    logic                                   fetch_kill, fetch_inval_buffer, fetch_inval_cache;
    logic                                   resp_valid, resp_fault;
    logic [fetch_pkg::INSTR_SIZE-1:0]       resp_data;
    // Interface and cache
    logic                                   icache_req_valid, icache_req_kill, icache_invalidate;
    logic [fetch_pkg::VPN_SIZE-1:0]         icache_req_vpn;
    logic [fetch_pkg::IDX_SIZE-1:0]         icache_req_idx;
    logic                                   icache_req_ready, icache_resp_valid, tlb_xcpt;
    logic [icache_pkg::LINE_BITS-1:0]       icache_resp_line;
    // Interface and boot ROM
    logic                                   brom_req_valid, brom_ready, brom_resp_valid;
    logic [fetch_pkg::BROM_ADDR_SIZE-1:0]   brom_req_address;
    logic [fetch_pkg::INSTR_SIZE-1:0]       brom_resp_data;

    pc_gen i_pc_gen (
        .clk_i, .rstn_i, .stall_i, .redirect_valid_i, .redirect_pc_i, .invalidate_i,
        .req_ready_i        (req_fetch_ready),
        .resp_valid_i       (resp_valid),
        .resp_data_i        (resp_data),
        .resp_fault_i       (resp_fault),
        .req_valid_o        (fetch_req_valid),
        .req_vaddr_o        (fetch_vaddr),
        .req_kill_o         (fetch_kill),
        .req_inval_buffer_o (fetch_inval_buffer),
        .req_inval_cache_o  (fetch_inval_cache),
        .instr_valid_o, .instr_pc_o, .instr_o, .instr_fault_o
    );

    icache_interface i_icache_interface (
        .clk_i, .rstn_i, .en_translation_i, .csr_spi_config_i,
        .req_valid_i         (fetch_req_valid),
        .req_vaddr_i         (fetch_vaddr),
        .req_kill_i          (fetch_kill),
        .req_inval_buffer_i  (fetch_inval_buffer),
        .req_inval_cache_i   (fetch_inval_cache),
        .icache_resp_line_i  (icache_resp_line),
        .icache_resp_valid_i (icache_resp_valid),
        .icache_req_ready_i  (icache_req_ready),
        .tlb_xcpt_i          (tlb_xcpt),
        .brom_ready_i        (brom_ready),
        .brom_resp_valid_i   (brom_resp_valid),
        .brom_resp_data_i    (brom_resp_data),
        .icache_invalidate_o (icache_invalidate),
        .icache_req_idx_o    (icache_req_idx),
        .icache_req_vpn_o    (icache_req_vpn),
        .icache_req_kill_o   (icache_req_kill),
        .icache_req_valid_o  (icache_req_valid),
        .brom_req_address_o  (brom_req_address),
        .brom_req_valid_o    (brom_req_valid),
        .resp_valid_o        (resp_valid),
        .resp_data_o         (resp_data),
        .resp_fault_o        (resp_fault),
        .req_ready_o         (req_fetch_ready)
    );

    icache_array i_icache_array (
        .clk_i, .rstn_i, .en_translation_i,
        .req_valid_i  (icache_req_valid),
        .req_vpn_i    (icache_req_vpn),
        .req_idx_i    (icache_req_idx),
        .req_kill_i   (icache_req_kill),
        .invalidate_i (icache_invalidate),
        .req_ready_o  (icache_req_ready),
        .resp_valid_o (icache_resp_valid),
        .resp_line_o  (icache_resp_line),
        .tlb_xcpt_o   (tlb_xcpt),
        .miss_o       (icache_miss_o)
    );

    boot_rom i_boot_rom (
        .clk_i, .rstn_i,
        .req_valid_i   (brom_req_valid),
        .req_address_i (brom_req_address),
        .ready_o       (brom_ready),
        .resp_valid_o  (brom_resp_valid),
        .resp_data_o   (brom_resp_data)
    );

endmodule

`default_nettype wire

//--- verification/tb_fetch_frontend.sv
// ---------------------------------------------------------------------
// Fetch front end testbench
// Boot ROM, cache, random stall and redirect, page fault and invalidate
// runs, checked by concurrent assertions against a small PC/line model
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_frontend;

    localparam logic [31:0] SEED          = 32'h7e5e_d775;
    localparam int unsigned RANDOM_CYCLES = 300;
    localparam int unsigned CYCLE_LIMIT   = 4000;  // Tests take about 500 cycles
    localparam int unsigned LINE_BYTES    = icache_pkg::LINE_BITS / 8;

    logic                                clk_i;
    logic                                rstn_i;
    logic                                redirect_valid_i;
    logic [fetch_pkg::ADDR_SIZE-1:0]     redirect_pc_i;
    logic                                invalidate_i;
    logic                                stall_i;
    logic                                en_translation_i;
    logic                                csr_spi_config_i;
    logic                                instr_valid_o;
    logic [fetch_pkg::ADDR_SIZE-1:0]     instr_pc_o;
    logic [fetch_pkg::INSTR_SIZE-1:0]    instr_o;
    logic                                instr_fault_o;
    logic                                icache_miss_o;

    // Model state
    logic [fetch_pkg::ADDR_SIZE-1:0]     exp_pc;       // Next PC to be delivered
    logic                                line_ok [icache_pkg::NUM_LINES];
    logic [fetch_pkg::ADDR_SIZE-1:0]     line_tag [icache_pkg::NUM_LINES];
    logic [fetch_pkg::ADDR_SIZE-1:0]     line_no;
    logic                                line_cached;
    logic [fetch_pkg::ADDR_SIZE-1:0]     fill_no;      // Line of the refill in flight
    int unsigned                         fill_wait;    // Cycles until that line is written
    int unsigned                         miss_seen;    // Miss pulses for the current fetch
    int unsigned                         cycle_count = 0;
    logic [31:0]                         rng;

    fetch_frontend i_fetch_frontend (
        .clk_i, .rstn_i, .redirect_valid_i, .redirect_pc_i, .invalidate_i, .stall_i,
        .en_translation_i, .csr_spi_config_i,
        .instr_valid_o, .instr_pc_o, .instr_o, .instr_fault_o, .icache_miss_o
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic page_fault(input logic [fetch_pkg::ADDR_SIZE-1:0] pc,
                                        input logic tr);
        return tr && (pc[fetch_pkg::ADDR_SIZE-1:12] > icache_pkg::VPN_LIMIT);
    endfunction

    // Boot window: translation off, SPI clear, below the ROM size
    function automatic logic from_rom(input logic [fetch_pkg::ADDR_SIZE-1:0] pc,
                                      input logic tr, input logic spi);
        return !tr && !spi && (pc < fetch_pkg::ADDR_SIZE'(fetch_pkg::BROM_SIZE));
    endfunction

    function automatic logic [31:0] expected_word(input logic [fetch_pkg::ADDR_SIZE-1:0] pc,
                                                  input logic tr, input logic spi);
        if (page_fault(pc, tr)) begin
            return '0;  // Faults return zero
        end
        if (from_rom(pc, tr, spi)) begin
            return pc[31:0] ^ fetch_pkg::BROM_PATTERN;
        end
        return pc[31:0] ^ icache_pkg::INSTR_PATTERN;
    endfunction

    function automatic int unsigned expected_misses(input logic [fetch_pkg::ADDR_SIZE-1:0] pc,
                                                    input logic tr, input logic spi,
                                                    input logic cached);
        if (page_fault(pc, tr) || from_rom(pc, tr, spi) || cached) begin
            return 0;
        end
        return 1;
    endfunction

    task automatic end_with_failure();
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped after a failed check");
    endtask

    task automatic report_mismatch(input string what);
        $display("MISMATCH at time %0t: %s", $time, what);
        end_with_failure();
    endtask

    // Returns once n instructions came out, timeout covers a stuck DUT
    task automatic wait_instrs(input int unsigned n);
        int unsigned seen;
        seen = 0;
        while (seen < n) begin
            @(posedge clk_i);
            if (instr_valid_o) seen++;
        end
    endtask

    // One-cycle redirect, config and invalidate change with it
    task automatic redirect_to(input logic [fetch_pkg::ADDR_SIZE-1:0] pc, input logic tr,
                               input logic spi, input logic inval);
        redirect_valid_i <= 1'b1;
        redirect_pc_i    <= pc;
        en_translation_i <= tr;
        csr_spi_config_i <= spi;
        invalidate_i     <= inval;
        @(posedge clk_i);
        redirect_valid_i <= 1'b0;
        invalidate_i     <= 1'b0;
    endtask

    // Line lookup in the model
    assign line_no     = exp_pc / fetch_pkg::ADDR_SIZE'(LINE_BYTES);
    assign line_cached = line_ok[line_no % icache_pkg::NUM_LINES] &&
                         (line_tag[line_no % icache_pkg::NUM_LINES] == line_no);

    always @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            exp_pc    <= fetch_pkg::RESET_PC;
            miss_seen <= 0;
            fill_wait <= 0;
            for (int i = 0; i < icache_pkg::NUM_LINES; i++) line_ok[i] <= 1'b0;
        end else begin
            // Line written in the response cycle, even if a redirect drops it
            if (fill_wait == 1) begin
                line_ok[fill_no % icache_pkg::NUM_LINES]  <= 1'b1;
                line_tag[fill_no % icache_pkg::NUM_LINES] <= fill_no;
                fill_wait <= 0;
            end else if (fill_wait > 1) begin
                fill_wait <= redirect_valid_i ? 0 : fill_wait - 1;  // Killed refill
            end
            if (invalidate_i) begin
                for (int i = 0; i < icache_pkg::NUM_LINES; i++) line_ok[i] <= 1'b0;
            end
            if (redirect_valid_i) begin
                exp_pc    <= redirect_pc_i;
                miss_seen <= 0;   // Miss of a dropped fetch
            end else if (instr_valid_o) begin
                exp_pc    <= exp_pc + fetch_pkg::ADDR_SIZE'(4);
                miss_seen <= 0;
            end else if (icache_miss_o) begin
                miss_seen <= miss_seen + 1;
                fill_no   <= line_no;
                fill_wait <= icache_pkg::REFILL_CYCLES;  // Response this many cycles on
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            end_with_failure();
        end
    end

    a_reset_quiet: assert property (@(posedge clk_i)
        !rstn_i |=> !instr_valid_o && !icache_miss_o)
        else report_mismatch("valid or miss output high in or right after reset");

    a_pc_order: assert property (@(posedge clk_i) disable iff (!rstn_i)
        instr_valid_o |-> instr_pc_o == exp_pc)
        else report_mismatch($sformatf("pc %h, expected %h",
                                       $sampled(instr_pc_o), $sampled(exp_pc)));

    a_word: assert property (@(posedge clk_i) disable iff (!rstn_i)
        instr_valid_o |-> instr_o == expected_word(exp_pc, en_translation_i, csr_spi_config_i))
        else report_mismatch($sformatf("word %h at pc %h, expected %h", $sampled(instr_o),
                                       $sampled(exp_pc),
                                       expected_word($sampled(exp_pc),
                                                     $sampled(en_translation_i),
                                                     $sampled(csr_spi_config_i))));

    a_fault: assert property (@(posedge clk_i) disable iff (!rstn_i)
        instr_valid_o |-> instr_fault_o == page_fault(exp_pc, en_translation_i))
        else report_mismatch($sformatf("fault flag %b at pc %h",
                                       $sampled(instr_fault_o), $sampled(exp_pc)));

    // Exactly one miss per new cache line, none for hits, faults or ROM
    a_miss_count: assert property (@(posedge clk_i) disable iff (!rstn_i)
        instr_valid_o |-> miss_seen == expected_misses(exp_pc, en_translation_i,
                                                       csr_spi_config_i, line_cached))
        else report_mismatch($sformatf("%0d miss pulses for pc %h",
                                       $sampled(miss_seen), $sampled(exp_pc)));

    a_miss_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
        icache_miss_o |=> !icache_miss_o)
        else report_mismatch("miss pulse longer than one cycle");

    a_drop: assert property (@(posedge clk_i) disable iff (!rstn_i)
        redirect_valid_i |-> !instr_valid_o)
        else report_mismatch("instruction delivered during a redirect");

    // Stalled right after a response, so nothing may follow next cycle
    a_stall_holds: assert property (@(posedge clk_i) disable iff (!rstn_i)
        instr_valid_o ##1 stall_i |=> !instr_valid_o)
        else report_mismatch("instruction delivered after a fetch under stall");

    initial begin
        rng              = SEED;
        rstn_i           = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        invalidate_i     = 1'b0;
        stall_i          = 1'b0;
        en_translation_i = 1'b0;
        csr_spi_config_i = 1'b0;
        repeat (3) @(posedge clk_i);
        rstn_i <= 1'b1;

        wait_instrs(8);                                       // Boot ROM from reset
        redirect_to(40'h00_0000_2000, 1'b0, 1'b0, 1'b0);      // Cache above the ROM
        wait_instrs(12);
        redirect_to(40'h00_0000_0100, 1'b0, 1'b1, 1'b0);      // SPI set, low address
        wait_instrs(8);

        redirect_to(40'h00_0000_0080, 1'b0, 1'b0, 1'b0);
        repeat (RANDOM_CYCLES) begin
            rng = lcg_next(rng);
            stall_i          <= (rng[30:28] < 3'd2);
            redirect_valid_i <= (rng[15:11] == 5'd0);
            // ROM window or a cache region that aliases the earlier lines
            redirect_pc_i    <= (rng[31] ? 40'h00_0000_3000 : 40'h0) + {rng[9:2], 2'b00};
            @(posedge clk_i);
        end
        stall_i          <= 1'b0;
        redirect_valid_i <= 1'b0;
        wait_instrs(2);

        redirect_to(40'h00_0001_0000, 1'b1, 1'b0, 1'b0);      // Page above the limit
        wait_instrs(3);
        redirect_to(40'h00_0000_F000, 1'b1, 1'b0, 1'b0);      // Page at the limit
        wait_instrs(4);

        redirect_to(40'h00_0000_2000, 1'b0, 1'b0, 1'b0);      // Line cached again
        wait_instrs(4);
        redirect_to(40'h00_0000_2000, 1'b0, 1'b0, 1'b1);      // Invalidate, then refetch
        wait_instrs(4);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
hdl/fetch_pkg.sv
hdl/icache_pkg.sv
hdl/pc_gen.sv
hdl/icache_interface.sv
hdl/icache_array.sv
hdl/boot_rom.sv
hdl/fetch_frontend.sv
verification/tb_fetch_frontend.sv

//--- Bender.yml
package:
  name: fetch_frontend

sources:
  # Packages before the modules that use them
  - target: rtl
    files:
      - hdl/fetch_pkg.sv
      - hdl/icache_pkg.sv
      - hdl/pc_gen.sv
      - hdl/icache_interface.sv
      - hdl/icache_array.sv
      - hdl/boot_rom.sv
      - hdl/fetch_frontend.sv

  - target: test
    files:
      - verification/tb_fetch_frontend.sv
